//--- design/i2c_touch_defines.svh
`ifndef I2C_TOUCH_DEFINES_SVH
`define I2C_TOUCH_DEFINES_SVH

// Bus phase timing, one phase per SCL half-step
`define BIT_PHASE_CYCLES 128
`define PHASE_CNT_W      7

// Touch controller
`define TOUCH_SLAVE_ADDR 7'h38

// Coordinate registers, stepped one per transaction
`define FIRST_DATA_ADDR  8'h03
`define LAST_DATA_ADDR   8'h06

`define BYTE_BITS        8

`endif

//--- design/i2c_touch_pkg.sv
package i2c_touch_pkg;

    `include "i2c_touch_defines.svh"

    typedef logic [`BYTE_BITS-1:0]   i2c_byte_t;    // One byte on the bus
    typedef logic [2:0]              bit_index_t;   // Bit position inside a byte
    typedef logic [`PHASE_CNT_W-1:0] phase_count_t; // Bit timer count

    typedef enum logic {
        TIMER_IDLE,
        TIMER_COUNTING
    } timer_state_t;

    // Each phase is a setup cycle followed by a timed wait
    typedef enum logic [4:0] {
        LINE_IDLE,
        START_SDA_SETUP, START_SDA_WAIT,
        START_SCL_SETUP, START_SCL_WAIT,
        BIT_SDA_SETUP,   BIT_SDA_WAIT,
        BIT_SCLH_SETUP,  BIT_SCLH_WAIT,
        BIT_SCLL_SETUP,  BIT_SCLL_WAIT,
        STOP_SDA_SETUP,  STOP_SDA_WAIT,
        STOP_SCL_SETUP,  STOP_SCL_WAIT,
        STOP_RISE_SETUP, STOP_RISE_WAIT,
        LINE_DONE
    } line_state_t;

    typedef enum logic [2:0] {
        SER_IDLE, SER_START, SER_BITS, SER_STOP, SER_WAIT, SER_DONE
    } ser_state_t;

    typedef enum logic [3:0] {
        SEQ_IDLE, SEQ_START_1, SEQ_ADDR_W, SEQ_DATA_ADDR, SEQ_STOP_1,
        SEQ_START_2, SEQ_ADDR_R, SEQ_STOP_2, SEQ_FINISH
    } seq_state_t;

endpackage

//--- design/bit_timer.sv
`timescale 1ns/1ps
`include "i2c_touch_defines.svh"

module bit_timer (
    input  logic clk,
    input  logic nRst,
    input  logic phase_start, // Only while idle
    output logic phase_done   // One cycle, BIT_PHASE_CYCLES after phase_start
);
    import i2c_touch_pkg::*;

    localparam phase_count_t LAST_COUNT = phase_count_t'(`BIT_PHASE_CYCLES - 1);

    timer_state_t timer_state;
    timer_state_t timer_state_n;
    phase_count_t phase_count;
    phase_count_t phase_count_n;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            timer_state <= TIMER_IDLE;
            phase_count <= '0;
        end else begin
            timer_state <= timer_state_n;
            phase_count <= phase_count_n;
        end
    end

    always_comb begin
        timer_state_n = timer_state;
        phase_count_n = phase_count;

        case (timer_state)
            TIMER_IDLE: begin
                phase_count_n = '0;
                if (phase_start) begin
                    timer_state_n = TIMER_COUNTING;
                end
            end
            TIMER_COUNTING: begin
                phase_count_n = phase_count + 1'b1;
                if (phase_count == LAST_COUNT) begin
                    timer_state_n = TIMER_IDLE; // Ready for the next setup cycle
                    phase_count_n = '0;
                end
            end
            default: timer_state_n = TIMER_IDLE;
        endcase
    end

    assign phase_done = (timer_state == TIMER_COUNTING) && (phase_count == LAST_COUNT);

endmodule

//--- design/bus_line_driver.sv
`timescale 1ns/1ps

module bus_line_driver (
    input  logic clk,
    input  logic nRst,
    input  logic line_start_req,
    input  logic line_bit_req,
    input  logic line_stop_req,
    input  logic bit_value,   // Valid with line_bit_req
    output logic line_credit, // Request finished on the bus
    output logic scl_out,
    output logic sda_out
);
    import i2c_touch_pkg::*;

    line_state_t line_state;
    line_state_t line_state_n;
    logic        scl_n;
    logic        sda_n;
    logic        bit_hold;
    logic        phase_start;
    logic        phase_done;

    bit_timer timer0 (
        .clk         (clk),
        .nRst        (nRst),
        .phase_start (phase_start),
        .phase_done  (phase_done)
    );

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            line_state <= LINE_IDLE;
            scl_out    <= 1'b1; // Bus released
            sda_out    <= 1'b1;
        end else begin
            line_state <= line_state_n;
            scl_out    <= scl_n;
            sda_out    <= sda_n;
        end
    end

    always_ff @(posedge clk) begin
        if (line_bit_req) begin
            bit_hold <= bit_value;
        end
    end

    // Line changes land at the end of each timed phase
    always_comb begin
        line_state_n = line_state;
        scl_n        = scl_out;
        sda_n        = sda_out;
        phase_start  = 1'b0;

        case (line_state)
            LINE_IDLE: begin
                if (line_start_req) begin
                    line_state_n = START_SDA_SETUP;
                end else if (line_bit_req) begin
                    line_state_n = BIT_SDA_SETUP;
                end else if (line_stop_req) begin
                    line_state_n = STOP_SDA_SETUP;
                end
            end

            // Start, SDA falls while SCL is high
            START_SDA_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = START_SDA_WAIT;
            end
            START_SDA_WAIT: begin
                if (phase_done) begin
                    sda_n        = 1'b0;
                    line_state_n = START_SCL_SETUP;
                end
            end
            START_SCL_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = START_SCL_WAIT;
            end
            START_SCL_WAIT: begin
                if (phase_done) begin
                    scl_n        = 1'b0;
                    line_state_n = LINE_DONE;
                end
            end

            // Data bit, SDA only moves while SCL is low
            BIT_SDA_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = BIT_SDA_WAIT;
            end
            BIT_SDA_WAIT: begin
                if (phase_done) begin
                    sda_n        = bit_hold;
                    line_state_n = BIT_SCLH_SETUP;
                end
            end
            BIT_SCLH_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = BIT_SCLH_WAIT;
            end
            BIT_SCLH_WAIT: begin
                if (phase_done) begin
                    scl_n        = 1'b1; // Slave samples here
                    line_state_n = BIT_SCLL_SETUP;
                end
            end
            BIT_SCLL_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = BIT_SCLL_WAIT;
            end
            BIT_SCLL_WAIT: begin
                if (phase_done) begin
                    scl_n        = 1'b0;
                    line_state_n = LINE_DONE;
                end
            end

            // Stop, SDA pulled low first so the final rise is a real edge
            STOP_SDA_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = STOP_SDA_WAIT;
            end
            STOP_SDA_WAIT: begin
                if (phase_done) begin
                    sda_n        = 1'b0;
                    line_state_n = STOP_SCL_SETUP;
                end
            end
            STOP_SCL_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = STOP_SCL_WAIT;
            end
            STOP_SCL_WAIT: begin
                if (phase_done) begin
                    scl_n        = 1'b1;
                    line_state_n = STOP_RISE_SETUP;
                end
            end
            STOP_RISE_SETUP: begin
                phase_start  = 1'b1;
                line_state_n = STOP_RISE_WAIT;
            end
            STOP_RISE_WAIT: begin
                if (phase_done) begin
                    sda_n        = 1'b1;
                    line_state_n = LINE_DONE;
                end
            end

            LINE_DONE: line_state_n = LINE_IDLE;
            default:   line_state_n = LINE_IDLE;
        endcase
    end

    assign line_credit = (line_state == LINE_DONE);

endmodule

//--- design/byte_serializer.sv
`timescale 1ns/1ps
`include "i2c_touch_defines.svh"

module byte_serializer (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  start_req,
    input  logic                  byte_req,
    input  logic                  stop_req,
    input  i2c_touch_pkg::i2c_byte_t tx_byte, // Valid with byte_req
    output logic                  op_credit,
    output logic                  line_start_req,
    output logic                  line_bit_req,
    output logic                  line_stop_req,
    output logic                  bit_value,
    input  logic                  line_credit
);
    import i2c_touch_pkg::*;

    localparam bit_index_t TOP_BIT = bit_index_t'(`BYTE_BITS - 1);

    ser_state_t ser_state;
    ser_state_t ser_state_n;
    bit_index_t bit_idx;
    bit_index_t bit_idx_n;
    i2c_byte_t  tx_hold;
    logic       line_have; // One credit towards the line driver
    logic       line_spend;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ser_state <= SER_IDLE;
            bit_idx   <= '0;
            line_have <= 1'b1;
        end else begin
            ser_state <= ser_state_n;
            bit_idx   <= bit_idx_n;
            if (line_credit) begin
                line_have <= 1'b1;
            end else if (line_spend) begin
                line_have <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_req && (ser_state == SER_IDLE)) begin
            tx_hold <= tx_byte;
        end
    end

    always_comb begin
        ser_state_n    = ser_state;
        bit_idx_n      = bit_idx;
        line_start_req = 1'b0;
        line_bit_req   = 1'b0;
        line_stop_req  = 1'b0;

        case (ser_state)
            SER_IDLE: begin
                if (start_req) begin
                    ser_state_n = SER_START;
                end else if (byte_req) begin
                    bit_idx_n   = TOP_BIT; // MSB first
                    ser_state_n = SER_BITS;
                end else if (stop_req) begin
                    ser_state_n = SER_STOP;
                end
            end
            SER_START: begin
                if (line_have) begin
                    line_start_req = 1'b1;
                    ser_state_n    = SER_WAIT;
                end
            end
            SER_BITS: begin
                if (line_have) begin
                    line_bit_req = 1'b1;
                    if (bit_idx == '0) begin
                        ser_state_n = SER_WAIT;
                    end else begin
                        bit_idx_n = bit_idx - 1'b1;
                    end
                end
            end
            SER_STOP: begin
                if (line_have) begin
                    line_stop_req = 1'b1;
                    ser_state_n   = SER_WAIT;
                end
            end
            SER_WAIT: begin
                if (line_credit) begin // Last line request is off the bus
                    ser_state_n = SER_DONE;
                end
            end
            SER_DONE: ser_state_n = SER_IDLE;
            default:  ser_state_n = SER_IDLE;
        endcase
    end

    assign line_spend = line_start_req | line_bit_req | line_stop_req;
    assign bit_value  = tx_hold[bit_idx];
    assign op_credit  = (ser_state == SER_DONE);

endmodule

//--- design/i2c_sequencer.sv
`timescale 1ns/1ps
`include "i2c_touch_defines.svh"

module i2c_sequencer (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  inter,     // Active low, from the touch controller
    output logic                  start_req,
    output logic                  byte_req,
    output logic                  stop_req,
    output i2c_touch_pkg::i2c_byte_t tx_byte,
    input  logic                  op_credit,
    output logic                  done       // One cycle at the end of a transaction
);
    import i2c_touch_pkg::*;

    localparam i2c_byte_t ADDR_WRITE = {`TOUCH_SLAVE_ADDR, 1'b0}; // 0x70
    localparam i2c_byte_t ADDR_READ  = {`TOUCH_SLAVE_ADDR, 1'b1}; // 0x71
    localparam i2c_byte_t FIRST_ADDR = `FIRST_DATA_ADDR;
    localparam i2c_byte_t LAST_ADDR  = `LAST_DATA_ADDR;

    seq_state_t seq_state;
    seq_state_t seq_state_n;
    logic       inter_meta;
    logic       inter_sync;
    logic       op_have;   // One credit towards the serializer
    logic       op_spend;
    i2c_byte_t  data_addr;
    i2c_byte_t  data_addr_n;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            inter_meta <= 1'b1;
            inter_sync <= 1'b1;
            seq_state  <= SEQ_IDLE;
            op_have    <= 1'b1;
            data_addr  <= FIRST_ADDR;
        end else begin
            inter_meta <= inter;
            inter_sync <= inter_meta;
            seq_state  <= seq_state_n;
            data_addr  <= data_addr_n;
            if (op_credit) begin
                op_have <= 1'b1;
            end else if (op_spend) begin
                op_have <= 1'b0;
            end
        end
    end

    // Every operation state waits for the credit of the one before it
    always_comb begin
        seq_state_n = seq_state;
        data_addr_n = data_addr;
        start_req   = 1'b0;
        byte_req    = 1'b0;
        stop_req    = 1'b0;
        tx_byte     = '0;
        done        = 1'b0;

        case (seq_state)
            SEQ_IDLE: begin
                if (!inter_sync) begin // Touch pending
                    seq_state_n = SEQ_START_1;
                end
            end
            SEQ_START_1: begin
                if (op_have) begin
                    start_req   = 1'b1;
                    seq_state_n = SEQ_ADDR_W;
                end
            end
            SEQ_ADDR_W: begin
                tx_byte = ADDR_WRITE;
                if (op_have) begin
                    byte_req    = 1'b1;
                    seq_state_n = SEQ_DATA_ADDR;
                end
            end
            SEQ_DATA_ADDR: begin
                tx_byte = data_addr;
                if (op_have) begin
                    byte_req    = 1'b1;
                    seq_state_n = SEQ_STOP_1;
                end
            end
            SEQ_STOP_1: begin
                if (op_have) begin
                    stop_req    = 1'b1;
                    seq_state_n = SEQ_START_2;
                end
            end
            SEQ_START_2: begin
                if (op_have) begin
                    start_req   = 1'b1;
                    seq_state_n = SEQ_ADDR_R;
                end
            end
            SEQ_ADDR_R: begin
                tx_byte = ADDR_READ;
                if (op_have) begin
                    byte_req    = 1'b1;
                    seq_state_n = SEQ_STOP_2;
                end
            end
            SEQ_STOP_2: begin
                if (op_have) begin
                    stop_req    = 1'b1;
                    seq_state_n = SEQ_FINISH;
                end
            end
            SEQ_FINISH: begin
                if (op_credit) begin // Final stop is on the bus
                    done        = 1'b1;
                    data_addr_n = (data_addr == LAST_ADDR) ? FIRST_ADDR : data_addr + 1'b1;
                    seq_state_n = SEQ_IDLE;
                end
            end
            default: seq_state_n = SEQ_IDLE;
        endcase
    end

    assign op_spend = start_req | byte_req | stop_req;

endmodule

//--- design/i2c_touch_reader.sv
`timescale 1ns/1ps

module i2c_touch_reader (
    input  logic clk,
    input  logic nRst,
    input  logic inter,   // Touch interrupt, active low
    output logic scl_out,
    output logic sda_out,
    output logic done
);
    import i2c_touch_pkg::*;

    // Sequencer to serializer
    logic      start_req;
    logic      byte_req;
    logic      stop_req;
    i2c_byte_t tx_byte;
    logic      op_credit;

    // Serializer to line driver
    logic      line_start_req;
    logic      line_bit_req;
    logic      line_stop_req;
    logic      bit_value;
    logic      line_credit;

    i2c_sequencer seq0 (
        .clk       (clk),
        .nRst      (nRst),
        .inter     (inter),
        .start_req (start_req),
        .byte_req  (byte_req),
        .stop_req  (stop_req),
        .tx_byte   (tx_byte),
        .op_credit (op_credit),
        .done      (done)
    );

    byte_serializer ser0 (
        .clk            (clk),
        .nRst           (nRst),
        .start_req      (start_req),
        .byte_req       (byte_req),
        .stop_req       (stop_req),
        .tx_byte        (tx_byte),
        .op_credit      (op_credit),
        .line_start_req (line_start_req),
        .line_bit_req   (line_bit_req),
        .line_stop_req  (line_stop_req),
        .bit_value      (bit_value),
        .line_credit    (line_credit)
    );

    bus_line_driver drv0 (
        .clk            (clk),
        .nRst           (nRst),
        .line_start_req (line_start_req),
        .line_bit_req   (line_bit_req),
        .line_stop_req  (line_stop_req),
        .bit_value      (bit_value),
        .line_credit    (line_credit),
        .scl_out        (scl_out),
        .sda_out        (sda_out)
    );

endmodule

//--- sim/tb_i2c_touch_reader.sv
`timescale 1ns/1ps
`include "i2c_touch_defines.svh"

module tb_i2c_touch_reader;
    import i2c_touch_pkg::*;

    localparam int          NUM_EPISODES     = 14;
    localparam int          PHASES_PER_TRANS = 82; // 2 starts, 2 stops, 24 bits
    localparam int          CLK_PERIOD_NS    = 8;
    localparam int          MARGIN_CYCLES    = 4000;
    localparam int          LAST_POS         = 6;  // Index of the final stop
    localparam int          NUM_DATA_ADDRS   = `LAST_DATA_ADDR - `FIRST_DATA_ADDR + 1;
    localparam logic [31:0] LFSR_SEED        = 32'h6156_7b40;

    localparam logic [1:0] EV_START = 2'd0;
    localparam logic [1:0] EV_STOP  = 2'd1;
    localparam logic [1:0] EV_BYTE  = 2'd2;

    localparam i2c_byte_t ADDR_WRITE = {`TOUCH_SLAVE_ADDR, 1'b0};
    localparam i2c_byte_t ADDR_READ  = {`TOUCH_SLAVE_ADDR, 1'b1};

    logic clk;
    logic nRst;
    logic inter;
    logic scl_out;
    logic sda_out;
    logic done;

    // Stimulus plan
    logic [31:0] lfsr;
    int          gap_len [NUM_EPISODES];
    int          hold_len [NUM_EPISODES];  // Cycles if short, else transactions
    logic        short_pulse [NUM_EPISODES];
    int          total_trans;
    int          watchdog_ns;
    logic        limit_ready = 1'b0;
    logic        monitor_on = 1'b0;

    // Bus decoder and model state
    i2c_byte_t exp_addr      = `FIRST_DATA_ADDR;
    i2c_byte_t shift_reg     = '0;
    int        pos           = 0;     // Next expected event within a transaction
    int        bit_cnt       = 0;
    logic      armed         = 1'b0;  // A transaction may start
    logic      in_trans      = 1'b0;
    int        trans_started = 0;
    int        done_count    = 0;
    logic      prev_scl      = 1'b1;
    logic      prev_sda      = 1'b1;
    logic      prev_done     = 1'b0;
    int        cycle         = 0;
    int        last_change   = -1000;

    i2c_touch_reader dut0 (
        .clk     (clk),
        .nRst    (nRst),
        .inter   (inter),
        .scl_out (scl_out),
        .sda_out (sda_out),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic string event_name(input logic [1:0] kind);
        case (kind)
            EV_START: return "start";
            EV_STOP:  return "stop";
            default:  return "byte";
        endcase
    endfunction

    task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t got);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s expected 0x%02h, got 0x%02h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_event(input string name, input logic [1:0] exp, input logic [1:0] got);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s expected %s, got %s",
                                $time, name, event_name(exp), event_name(got)));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | {31'd0, lfsr[0]};
        end
    endtask

    task automatic plan_episodes();
        int ep;
        int kind;
        int val;
        int wait_total;
        total_trans = 0;
        wait_total  = 0;
        for (ep = 0; ep < NUM_EPISODES; ep++) begin
            draw_bits(8, val);
            gap_len[ep] = val;
            draw_bits(2, kind);
            short_pulse[ep] = (kind == 0);
            if (short_pulse[ep]) begin
                draw_bits(4, val);
                hold_len[ep] = val + 1;  // Low for 1 to 16 cycles
                total_trans  = total_trans + 1;
                wait_total   = wait_total + hold_len[ep];
            end else begin
                draw_bits(2, val);
                hold_len[ep] = val + 2;  // 2 to 5 transactions back to back
                total_trans  = total_trans + hold_len[ep];
            end
            wait_total = wait_total + gap_len[ep] + 1;
        end
        watchdog_ns = (total_trans * PHASES_PER_TRANS * (`BIT_PHASE_CYCLES + 2)
                       + wait_total + total_trans * 64 + MARGIN_CYCLES) * CLK_PERIOD_NS;
    endtask

    task automatic run_episode(input int ep);
        int base;
        base = done_count;
        repeat (gap_len[ep]) @(posedge clk);
        @(posedge clk);
        inter <= 1'b0;
        if (short_pulse[ep]) begin
            repeat (hold_len[ep]) @(posedge clk);
            inter <= 1'b1;
            wait (done_count == base + 1);
        end else begin
            // Release once the last wanted transaction is on the bus
            wait (trans_started == base + hold_len[ep]);
            @(posedge clk);
            inter <= 1'b1;
            wait (done_count == base + hold_len[ep]);
        end
    endtask

    function automatic logic [1:0] expected_kind(input int p);
        case (p)
            0, 4:    return EV_START;
            3, 6:    return EV_STOP;
            default: return EV_BYTE;
        endcase
    endfunction

    function automatic i2c_byte_t expected_byte(input int p);
        case (p)
            1:       return ADDR_WRITE;
            5:       return ADDR_READ;
            default: return exp_addr;
        endcase
    endfunction

    task automatic handle_bus_event(input logic [1:0] kind);
        if (pos > LAST_POS) begin
            abort_run($sformatf("Bus %s at %0t after the final stop, before done",
                                event_name(kind), $time));
        end
        check_event($sformatf("bus event %0d of transaction %0d", pos, trans_started),
                    expected_kind(pos), kind);
        if (pos == 0) begin
            if (!armed) begin
                abort_run($sformatf("Transaction started at %0t with no pending interrupt",
                                    $time));
            end
            armed         = 1'b0;
            in_trans      = 1'b1;
            trans_started = trans_started + 1;
        end
        pos = pos + 1;
    endtask

    task automatic handle_scl_rise();
        if ((pos > LAST_POS) || (expected_kind(pos) == EV_START)) begin
            abort_run($sformatf("SCL rose at %0t outside a byte or stop", $time));
        end else if (expected_kind(pos) == EV_STOP) begin
            check_bit("sda_out at the stop clock", 1'b0, sda_out);
        end else begin
            shift_reg = {shift_reg[`BYTE_BITS-2:0], sda_out}; // MSB first
            bit_cnt   = bit_cnt + 1;
            if (bit_cnt == `BYTE_BITS) begin
                check_byte($sformatf("byte %0d of transaction %0d", pos, trans_started),
                           expected_byte(pos), shift_reg);
                bit_cnt = 0;
                pos     = pos + 1;
            end
        end
    endtask

    task automatic handle_done();
        if (prev_done) begin
            abort_run($sformatf("done high for more than one cycle at %0t", $time));
        end
        if (pos != LAST_POS + 1) begin
            abort_run($sformatf("done at %0t before the final stop", $time));
        end
        done_count = done_count + 1;
        pos        = 0;
        in_trans   = 1'b0;
        armed      = !inter; // Level still low means another transaction
        // Coordinate registers repeat every NUM_DATA_ADDRS transactions
        exp_addr   = `FIRST_DATA_ADDR + i2c_byte_t'(done_count % NUM_DATA_ADDRS);
    endtask

    // Passive decoder sampling mid-cycle
    always @(negedge clk) begin
        if (monitor_on) begin
            cycle = cycle + 1;
            if ((scl_out !== prev_scl) || (sda_out !== prev_sda)) begin
                if (cycle - last_change < `BIT_PHASE_CYCLES) begin
                    abort_run($sformatf("Line changes at %0t only %0d cycles apart",
                                        $time, cycle - last_change));
                end
                last_change = cycle;
            end
            if ((scl_out !== prev_scl) && (sda_out !== prev_sda)) begin
                abort_run($sformatf("SCL and SDA changed in the same cycle at %0t", $time));
            end
            if (!inter && !in_trans) begin
                armed = 1'b1;
            end
            if (scl_out && prev_scl && (sda_out !== prev_sda)) begin
                handle_bus_event(sda_out ? EV_STOP : EV_START);
            end else if (scl_out && !prev_scl) begin
                handle_scl_rise();
            end
            if (done) begin
                handle_done();
            end else if (!in_trans) begin
                check_bit("scl_out", 1'b1, scl_out); // Bus released between transactions
                check_bit("sda_out", 1'b1, sda_out);
            end
            prev_scl  = scl_out;
            prev_sda  = sda_out;
            prev_done = done;
        end
    end

    initial begin
        wait (limit_ready);
        #(watchdog_ns);
        abort_run($sformatf("Timeout after %0d ns with %0d of %0d transactions done",
                            watchdog_ns, done_count, total_trans));
    end

    initial begin
        int ep;
        inter <= 1'b1;
        nRst  <= 1'b0;
        lfsr = LFSR_SEED;
        plan_episodes();
        limit_ready = 1'b1;
        repeat (3) @(posedge clk);
        nRst <= 1'b1;
        @(posedge clk);
        monitor_on = 1'b1;

        for (ep = 0; ep < NUM_EPISODES; ep++) begin
            run_episode(ep);
        end
        repeat (4 * `BIT_PHASE_CYCLES) @(posedge clk); // Nothing more may start

        if ((done_count == total_trans) && !in_trans && (pos == 0)) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run($sformatf("Saw %0d transactions, expected %0d", done_count, total_trans));
        end
    end

endmodule

//--- i2c_touch_reader.f
+incdir+design
design/i2c_touch_pkg.sv
design/bit_timer.sv
design/bus_line_driver.sv
design/byte_serializer.sv
design/i2c_sequencer.sv
design/i2c_touch_reader.sv
sim/tb_i2c_touch_reader.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f i2c_touch_reader.f \
    --top-module tb_i2c_touch_reader -o tb_i2c_touch_reader || exit 1
output=$(./obj_dir/tb_i2c_touch_reader 2>&1)
echo "$output"
echo "$output" | grep -q "Everything OK" && exit 0 || exit 1
